/* all.f */
verilog/lineDrawPkg.sv
verilog/lineRegQueue.sv
verilog/lineRasterizer.sv
verilog/pixelPort.sv
verilog/lineDrawTop.sv
bench/tbClock.sv
bench/tbLineDraw.sv

/* bench/tbClock.sv */
`timescale 1ns/1ns

module tbClock #(
	parameter int Period = 100,
	parameter int ResetCycles = 2
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever begin
			#(Period / 2) clk = ~clk;
		end
	end

	initial begin
		rst = 1'b1;
		repeat (ResetCycles) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;  // Released on a falling edge
	end

endmodule

/* bench/tbLineDraw.sv */
`timescale 1ns/1ns

module tbLineDraw
	import lineDrawPkg::*;
#(
	parameter int QueueDepth = 32
);

	localparam int PixelWidth = 2 * CoordWidth + IntensityWidth;
	localparam int DirectedCount = 9;
	localparam int FillWrites = QueueDepth + 4;
	localparam int RandomCount = 200;
	localparam int TimeoutCycles = (DirectedCount + FillWrites + RandomCount) * 64 * 8 + 2000;

	logic clk;
	logic rst;
	logic write;
	logic pixAck = 1'b0;
	logic [CoordWidth-1:0] dStartX;
	logic [CoordWidth-1:0] dStartY;
	logic [CoordWidth-1:0] dEndX;
	logic [CoordWidth-1:0] dEndY;
	logic [IntensityWidth-1:0] dIntensity;
	logic full;
	logic [CoordWidth-1:0] pixX;
	logic [CoordWidth-1:0] pixY;
	logic [IntensityWidth-1:0] pixIntensity;
	logic pixReq;
	logic idle;

	logic [PixelWidth-1:0] expectedPixels [$];  // Model output in order
	logic [PixelWidth-1:0] headPixel;
	logic [31:0] stimSeed = 32'd42978;
	logic [31:0] ackSeed = 32'd42978;
	logic lastReq = 1'b0;
	logic ackHold = 1'b0;  // Frame store stalls while set
	logic sawFull;
	int ackWait = 0;
	int releaseWait = 0;
	int pixelsSeen = 0;
	int cycleCount = 0;
	int errorCount = 0;
	int accepted = 0;
	int dropped = 0;

	tbClock #(.Period(100), .ResetCycles(2)) tbClock_i (.clk(clk), .rst(rst));

	lineDrawTop #(
		.LineQueueDepth(QueueDepth)
	) lineDrawTop_i (
		.clk(clk), .rst(rst), .write(write), .pixAck(pixAck),
		.dStartX(dStartX), .dStartY(dStartY), .dEndX(dEndX), .dEndY(dEndY),
		.dIntensity(dIntensity), .full(full),
		.pixX(pixX), .pixY(pixY), .pixIntensity(pixIntensity),
		.pixReq(pixReq), .idle(idle)
	);

	// ########################################
	// Helpers
	// ########################################

	function automatic logic [31:0] lcgNext(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic reportFailure(input string msg);
		errorCount++;
		$display("Error at %0t ns: %s", $time, msg);
		$display("FAIL: see errors above");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic checkEqual(input int actual, input int expectedValue, input string what);
		if (actual !== expectedValue) begin
			reportFailure($sformatf("%s: got %0d, expected %0d", what, actual,
				expectedValue));
		end
	endtask

	task automatic nextStim(input int limit, output int value);
		stimSeed = lcgNext(stimSeed);
		value = int'(stimSeed[30:16]) % limit;
	endtask

	// Bresenham reference model appending the ordered pixels of one segment
	task automatic expandSegment(input int x0, y0, x1, y1, inten);
		int dx;
		int dy;
		int err;
		int e2;
		int sx;
		int sy;
		int x;
		int y;
		bit done;
		dx = (x1 > x0) ? x1 - x0 : x0 - x1;
		dy = (y1 > y0) ? y0 - y1 : y1 - y0;  // Negated magnitude
		err = dx + dy;
		sx = (x0 < x1) ? 1 : -1;
		sy = (y0 < y1) ? 1 : -1;
		x = x0;
		y = y0;
		done = 1'b0;
		while (!done) begin
			expectedPixels.push_back({CoordWidth'(x), CoordWidth'(y),
				IntensityWidth'(inten)});
			if (x == x1 && y == y1) begin
				done = 1'b1;
			end else begin
				e2 = 2 * err;
				if (e2 >= dy) begin
					err += dy;
					x += sx;
				end
				if (e2 <= dx) begin
					err += dx;
					y += sy;
				end
			end
		end
	endtask

	// Call at a falling edge; write must already be low
	task automatic writeSegment(input int x0, y0, x1, y1, inten);
		dStartX = CoordWidth'(x0);
		dStartY = CoordWidth'(y0);
		dEndX = CoordWidth'(x1);
		dEndY = CoordWidth'(y1);
		dIntensity = IntensityWidth'(inten);
		write = 1'b1;
		if (!full) begin
			expandSegment(x0, y0, x1, y1, inten);
			accepted++;
		end else begin
			sawFull = 1'b1;
			dropped++;  // Queue ignores this edge
		end
		@(negedge clk);
		write = 1'b0;
	endtask

	task automatic writeRandomSegment();
		int x0;
		int y0;
		int x1;
		int y1;
		int inten;
		nextStim(64, x0);
		nextStim(64, y0);
		nextStim(64, x1);
		nextStim(64, y1);
		nextStim(16, inten);
		writeSegment(x0, y0, x1, y1, inten);
	endtask

	task automatic waitIdle();
		@(negedge clk);
		while (!idle) begin
			@(negedge clk);
		end
		checkEqual(expectedPixels.size(), 0, "expected pixels left at idle");
	endtask

	task automatic drawOne(input int x0, y0, x1, y1, inten);
		int spanX;
		int spanY;
		int firstPixel;
		spanX = (x1 > x0) ? x1 - x0 : x0 - x1;
		spanY = (y1 > y0) ? y1 - y0 : y0 - y1;
		@(negedge clk);
		firstPixel = pixelsSeen;
		writeSegment(x0, y0, x1, y1, inten);
		waitIdle();
		checkEqual(pixelsSeen - firstPixel, ((spanX > spanY) ? spanX : spanY) + 1,
			"pixel count of segment");
	endtask

	// ########################################
	// Monitor and frame-store responder
	// ########################################

	always @(negedge clk) begin
		if (!rst) begin
			if (pixReq && !lastReq) begin
				checkEqual(int'(pixAck), 0, "pixAck at pixReq rise");
				if (expectedPixels.size() == 0) begin
					reportFailure("pixel request arrived with no pixel expected");
				end
				headPixel = expectedPixels.pop_front();
				pixelsSeen++;
				checkEqual(int'(pixX), int'(headPixel[PixelWidth-1 -: CoordWidth]), "pixX");
				checkEqual(int'(pixY), int'(headPixel[CoordWidth+IntensityWidth-1 -: CoordWidth]),
					"pixY");
				checkEqual(int'(pixIntensity), int'(headPixel[IntensityWidth-1:0]),
					"pixIntensity");
				ackSeed = lcgNext(ackSeed);
				ackWait = int'(ackSeed[29:16]) % 4;  // 0 to 3 cycles
			end else if (pixReq) begin
				checkEqual(int'({pixX, pixY, pixIntensity}), int'(headPixel),
					"pixel held under pixReq");
			end
			lastReq = pixReq;
			if (pixReq && !pixAck && !ackHold) begin
				if (ackWait == 0) begin
					pixAck = 1'b1;
					ackSeed = lcgNext(ackSeed);
					releaseWait = int'(ackSeed[29:16]) % 4;
				end else begin
					ackWait--;
				end
			end else if (!pixReq && pixAck) begin
				if (releaseWait == 0) begin
					pixAck = 1'b0;
				end else begin
					releaseWait--;  // Frame store slow to drop ack
				end
			end
		end
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount > TimeoutCycles) begin
			reportFailure($sformatf("timeout after %0d cycles, %0d pixels still expected",
				cycleCount, expectedPixels.size()));
		end
	end

	// ########################################
	// Test sequence
	// ########################################

	initial begin
		int gap;
		write = 1'b0;
		dStartX = '0;
		dStartY = '0;
		dEndX = '0;
		dEndY = '0;
		dIntensity = '0;
		sawFull = 1'b0;

		@(negedge clk);
		while (rst) begin
			@(negedge clk);
		end
		checkEqual(int'(pixReq), 0, "pixReq after reset");
		checkEqual(int'(full), 0, "full after reset");
		checkEqual(int'(idle), 1, "idle after reset");

		// One line per octant and a point
		drawOne(32, 32, 60, 40, 1);
		drawOne(32, 32, 40, 60, 2);
		drawOne(32, 32, 24, 60, 3);
		drawOne(32, 32, 4, 40, 4);
		drawOne(32, 32, 4, 24, 5);
		drawOne(32, 32, 24, 4, 6);
		drawOne(32, 32, 40, 4, 7);
		drawOne(32, 32, 60, 24, 15);
		drawOne(17, 17, 17, 17, 9);
		$display("Single lines done at %0t ns", $time);

		// Stalled frame store fills the queue
		ackHold = 1'b1;
		sawFull = 1'b0;
		dropped = 0;
		for (int i = 0; i < FillWrites; i++) begin
			@(negedge clk);
			writeRandomSegment();
		end
		checkEqual(int'(sawFull), 1, "full seen during fill");
		checkEqual(int'(dropped > 0), 1, "writes dropped while full");
		ackHold = 1'b0;
		waitIdle();
		$display("Fill test done, %0d writes dropped", dropped);

		for (int i = 0; i < RandomCount; i++) begin
			@(negedge clk);
			nextStim(4, gap);
			repeat (gap) @(negedge clk);
			while (full) begin
				@(negedge clk);
			end
			writeRandomSegment();
		end
		waitIdle();
		$display("Random run done, %0d segments accepted in total", accepted);

		if (errorCount == 0) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			$display("FAIL: see errors above");
			$fatal(1, "Errors found");
		end
	end

endmodule

/* run.sh */
#!/bin/bash
# Build and run the line-draw testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "Cannot enter project directory"
	exit 1
fi

verilator --binary --timing -Wno-fatal --top-module tbLineDraw \
	-f all.f -Mdir obj_dir -o simLineDraw
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simLineDraw > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "PASS: all tests" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, exit status $simStatus"
	exit 1
fi

/* verilog/lineDrawPkg.sv */
package lineDrawPkg;

	// ########################################
	// Widths
	// ########################################

	localparam int CoordWidth = 13;
	localparam int IntensityWidth = 4;

	// ########################################
	// State encodings
	// ########################################

	typedef enum logic [1:0] {
		rasterIdle,   // Waiting for a segment
		rasterSetup,  // Deltas, directions, error term
		rasterStep    // Emitting pixels
	} rasterState;

	typedef enum logic [1:0] {
		portEmpty,    // Nothing held
		portReq,      // Request up, wait for ack
		portRelease   // Request down, wait for ack low
	} portState;

endpackage

/* verilog/lineDrawTop.sv */
`timescale 1ns/1ns

module lineDrawTop
	import lineDrawPkg::*;
#(
	parameter int LineQueueDepth = 32
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      write,
	input  logic                      pixAck,
	input  logic [CoordWidth-1:0]     dStartX,
	input  logic [CoordWidth-1:0]     dStartY,
	input  logic [CoordWidth-1:0]     dEndX,
	input  logic [CoordWidth-1:0]     dEndY,
	input  logic [IntensityWidth-1:0] dIntensity,
	output logic                      full,
	output logic [CoordWidth-1:0]     pixX,
	output logic [CoordWidth-1:0]     pixY,
	output logic [IntensityWidth-1:0] pixIntensity,
	output logic                      pixReq,
	output logic                      idle
);

	logic [CoordWidth-1:0] qStartX;
	logic [CoordWidth-1:0] qStartY;
	logic [CoordWidth-1:0] qEndX;
	logic [CoordWidth-1:0] qEndY;
	logic [IntensityWidth-1:0] qIntensity;
	logic empty;
	logic read;

	logic [CoordWidth-1:0] stepX;
	logic [CoordWidth-1:0] stepY;
	logic [IntensityWidth-1:0] stepIntensity;
	logic stepValid;
	logic stepReady;
	logic busy;

	lineRegQueue #(
		.LineQueueDepth(LineQueueDepth)
	) lineRegQueue_i (
		.clk(clk), .rst(rst), .write(write), .read(read),
		.dStartX(dStartX), .dStartY(dStartY), .dEndX(dEndX), .dEndY(dEndY),
		.dIntensity(dIntensity),
		.qStartX(qStartX), .qStartY(qStartY), .qEndX(qEndX), .qEndY(qEndY),
		.qIntensity(qIntensity), .full(full), .empty(empty)
	);

	lineRasterizer lineRasterizer_i (
		.clk(clk), .rst(rst), .empty(empty), .stepReady(stepReady),
		.qStartX(qStartX), .qStartY(qStartY), .qEndX(qEndX), .qEndY(qEndY),
		.qIntensity(qIntensity), .read(read), .stepValid(stepValid), .busy(busy),
		.stepX(stepX), .stepY(stepY), .stepIntensity(stepIntensity)
	);

	pixelPort pixelPort_i (
		.clk(clk), .rst(rst), .stepValid(stepValid), .pixAck(pixAck),
		.stepX(stepX), .stepY(stepY), .stepIntensity(stepIntensity),
		.stepReady(stepReady), .pixReq(pixReq),
		.pixX(pixX), .pixY(pixY), .pixIntensity(pixIntensity)
	);

	assign idle = empty && !busy && stepReady;  // All work drained

endmodule

/* verilog/lineRasterizer.sv */
`timescale 1ns/1ns

module lineRasterizer
	import lineDrawPkg::*;
(
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      empty,
	input  logic                      stepReady,
	input  logic [CoordWidth-1:0]     qStartX,
	input  logic [CoordWidth-1:0]     qStartY,
	input  logic [CoordWidth-1:0]     qEndX,
	input  logic [CoordWidth-1:0]     qEndY,
	input  logic [IntensityWidth-1:0] qIntensity,
	output logic                      read,
	output logic                      stepValid,
	output logic                      busy,
	output logic [CoordWidth-1:0]     stepX,
	output logic [CoordWidth-1:0]     stepY,
	output logic [IntensityWidth-1:0] stepIntensity
);

	rasterState state;

	logic [CoordWidth-1:0] curX;
	logic [CoordWidth-1:0] curY;
	logic [CoordWidth-1:0] endX;
	logic [CoordWidth-1:0] endY;
	logic [IntensityWidth-1:0] intensity;

	logic signed [CoordWidth+1:0] deltaX;  // Positive
	logic signed [CoordWidth+1:0] deltaY;  // Zero or negative
	logic signed [CoordWidth+1:0] err;
	logic xNeg;
	logic yNeg;

	logic signed [CoordWidth+1:0] diffX;
	logic signed [CoordWidth+1:0] diffY;
	logic signed [CoordWidth+1:0] absDiffX;
	logic signed [CoordWidth+1:0] negAbsDiffY;
	logic signed [CoordWidth+2:0] errDouble;
	logic moveX;
	logic moveY;
	logic atEnd;
	logic transfer;

	// ########################################
	// Setup and step arithmetic
	// ########################################

	always_comb begin
		diffX = $signed({2'b00, endX}) - $signed({2'b00, curX});
		diffY = $signed({2'b00, endY}) - $signed({2'b00, curY});
		absDiffX = (diffX < 0) ? -diffX : diffX;
		negAbsDiffY = (diffY < 0) ? diffY : -diffY;
	end

	assign errDouble = $signed({err, 1'b0});
	assign moveX = (errDouble >= deltaY);
	assign moveY = (errDouble <= deltaX);
	assign atEnd = (curX == endX) && (curY == endY);

	assign read = (state == rasterIdle) && !empty;
	assign stepValid = (state == rasterStep);
	assign transfer = stepValid && stepReady;
	assign busy = (state != rasterIdle);

	assign stepX = curX;
	assign stepY = curY;
	assign stepIntensity = intensity;

	// ########################################
	// Control
	// ########################################

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= rasterIdle;
		end else begin
			case (state)
				rasterIdle: begin
					if (read) begin
						state <= rasterSetup;
					end
				end
				rasterSetup: begin
					state <= rasterStep;
				end
				rasterStep: begin
					if (transfer && atEnd) begin
						state <= rasterIdle;  // Last pixel taken
					end
				end
				default: begin
					state <= rasterIdle;
				end
			endcase
		end
	end

	// Walk registers
	always_ff @(posedge clk) begin
		case (state)
			rasterIdle: begin
				if (read) begin
					curX <= qStartX;
					curY <= qStartY;
					endX <= qEndX;
					endY <= qEndY;
					intensity <= qIntensity;
				end
			end
			rasterSetup: begin
				deltaX <= absDiffX;
				deltaY <= negAbsDiffY;
				err <= absDiffX + negAbsDiffY;
				xNeg <= (diffX < 0);
				yNeg <= (diffY < 0);
			end
			rasterStep: begin
				if (transfer && !atEnd) begin
					if (moveX) begin
						curX <= xNeg ? curX - 1'b1 : curX + 1'b1;
					end
					if (moveY) begin
						curY <= yNeg ? curY - 1'b1 : curY + 1'b1;
					end
					// Both tests use the doubled error from before the step
					err <= err + (moveX ? deltaY : '0) + (moveY ? deltaX : '0);
				end
			end
			default: begin
			end
		endcase
	end

endmodule

/* verilog/lineRegQueue.sv */
`timescale 1ns/1ns

module lineRegQueue
	import lineDrawPkg::*;
#(
	parameter int LineQueueDepth = 32
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      write,
	input  logic                      read,
	input  logic [CoordWidth-1:0]     dStartX,
	input  logic [CoordWidth-1:0]     dStartY,
	input  logic [CoordWidth-1:0]     dEndX,
	input  logic [CoordWidth-1:0]     dEndY,
	input  logic [IntensityWidth-1:0] dIntensity,
	output logic [CoordWidth-1:0]     qStartX,
	output logic [CoordWidth-1:0]     qStartY,
	output logic [CoordWidth-1:0]     qEndX,
	output logic [CoordWidth-1:0]     qEndY,
	output logic [IntensityWidth-1:0] qIntensity,
	output logic                      full,
	output logic                      empty
);

	localparam int IndexWidth = $clog2(LineQueueDepth);
	localparam int CountWidth = IndexWidth + 1;

	logic [CoordWidth-1:0] startXMem [LineQueueDepth];
	logic [CoordWidth-1:0] startYMem [LineQueueDepth];
	logic [CoordWidth-1:0] endXMem [LineQueueDepth];
	logic [CoordWidth-1:0] endYMem [LineQueueDepth];
	logic [IntensityWidth-1:0] intensityMem [LineQueueDepth];

	logic [IndexWidth-1:0] writeIndex;
	logic [IndexWidth-1:0] readIndex;
	logic [CountWidth-1:0] fillCount;

	logic lastWrite;
	logic writeStrobe;
	logic doWrite;
	logic doRead;

	// ########################################
	// Write edge and pointer control
	// ########################################

	assign writeStrobe = write && !lastWrite;  // Rising edge of write
	assign doWrite = writeStrobe && !full;     // Dropped when full
	assign doRead = read && !empty;

	always_ff @(posedge clk) begin
		if (rst) begin
			lastWrite <= 1'b0;
			writeIndex <= '0;
			readIndex <= '0;
			fillCount <= '0;
		end else begin
			lastWrite <= write;
			if (doWrite) begin
				writeIndex <= writeIndex + 1'b1;  // Wraps at power-of-two depth
			end
			if (doRead) begin
				readIndex <= readIndex + 1'b1;
			end
			case ({doWrite, doRead})
				2'b10: begin
					fillCount <= fillCount + 1'b1;
				end
				2'b01: begin
					fillCount <= fillCount - 1'b1;
				end
				default: begin
					fillCount <= fillCount;  // Both or neither
				end
			endcase
		end
	end

	// ########################################
	// Segment storage
	// ########################################

	always_ff @(posedge clk) begin
		if (doWrite) begin
			startXMem[writeIndex] <= dStartX;
			startYMem[writeIndex] <= dStartY;
			endXMem[writeIndex] <= dEndX;
			endYMem[writeIndex] <= dEndY;
			intensityMem[writeIndex] <= dIntensity;
		end
	end

	// Oldest segment
	assign qStartX = startXMem[readIndex];
	assign qStartY = startYMem[readIndex];
	assign qEndX = endXMem[readIndex];
	assign qEndY = endYMem[readIndex];
	assign qIntensity = intensityMem[readIndex];

	assign full = (fillCount == CountWidth'(LineQueueDepth));
	assign empty = (fillCount == '0);

endmodule

/* verilog/pixelPort.sv */
`timescale 1ns/1ns

module pixelPort
	import lineDrawPkg::*;
(
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      stepValid,
	input  logic                      pixAck,
	input  logic [CoordWidth-1:0]     stepX,
	input  logic [CoordWidth-1:0]     stepY,
	input  logic [IntensityWidth-1:0] stepIntensity,
	output logic                      stepReady,
	output logic                      pixReq,
	output logic [CoordWidth-1:0]     pixX,
	output logic [CoordWidth-1:0]     pixY,
	output logic [IntensityWidth-1:0] pixIntensity
);

	portState state;
	logic transfer;

	assign stepReady = (state == portEmpty);
	assign transfer = stepValid && stepReady;
	assign pixReq = (state == portReq);

	// ########################################
	// Four-phase sequence
	// ########################################

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= portEmpty;
		end else begin
			case (state)
				portEmpty: begin
					if (transfer) begin
						state <= portReq;
					end
				end
				portReq: begin
					if (pixAck) begin
						state <= portRelease;  // Drop request
					end
				end
				portRelease: begin
					if (!pixAck) begin
						state <= portEmpty;
					end
				end
				default: begin
					state <= portEmpty;
				end
			endcase
		end
	end

	// Held pixel stays stable until the next transfer
	always_ff @(posedge clk) begin
		if (transfer) begin
			pixX <= stepX;
			pixY <= stepY;
			pixIntensity <= stepIntensity;
		end
	end

endmodule
